// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := miniSrcTb
FILELIST  := sources.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// ==== alu/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [srcPkg::wordWidth-1:0]   a,
    input  logic [srcPkg::wordWidth-1:0]   b,
    input  srcPkg::aluOp_t                 aluOp,
    input  logic                           incPc,
    output logic [2*srcPkg::wordWidth-1:0] result
);
    import srcPkg::*;

    logic signed [wordWidth-1:0]   aSigned;    // Y as signed.
    logic signed [wordWidth-1:0]   bSigned;    // bus as signed.
    logic signed [2*wordWidth-1:0] product;    // full signed product.
    logic [wordWidth-1:0]          quotient;
    logic [wordWidth-1:0]          remainder;
    logic [4:0]                    shiftAmount;
    logic [2*wordWidth-1:0]        rotateSrc;  // a doubled for rotates.
    logic [2*wordWidth-1:0]        rotRight;
    logic [2*wordWidth-1:0]        rotLeft;
    logic [wordWidth-1:0]          lowWord;
    logic [wordWidth-1:0]          highWord;

    assign aSigned     = a;
    assign bSigned     = b;
    assign product     = aSigned * bSigned;   // sign-extended to 64 bits.
    assign shiftAmount = b[4:0];              // low five bits only.
    assign rotateSrc   = {a, a};
    assign rotRight    = rotateSrc >> shiftAmount;
    assign rotLeft     = rotateSrc << shiftAmount;

    // divider, with a defined result for a zero divisor.
    always_comb begin
        if (b == '0) begin
            quotient  = '1;                   // all ones.
            remainder = a;                    // dividend kept.
        end else begin
            quotient  = aSigned / bSigned;
            remainder = aSigned % bSigned;    // sign follows dividend.
        end
    end

    always_comb begin
        lowWord  = '0;
        highWord = '0;                        // zero unless mul or div.
        if (incPc) begin
            lowWord = b + wordWidth'(1);      // PC increment overrides aluOp.
        end else begin
            case (aluOp)
                opAdd:  lowWord = a + b;
                opSub:  lowWord = a - b;
                opAnd:  lowWord = a & b;
                opOr:   lowWord = a | b;
                opShr:  lowWord = a >> shiftAmount;
                opShra: lowWord = aSigned >>> shiftAmount;
                opShl:  lowWord = a << shiftAmount;
                opRor:  lowWord = rotRight[wordWidth-1:0];
                opRol:  lowWord = rotLeft[2*wordWidth-1:wordWidth];
                opMul: begin
                    lowWord  = product[wordWidth-1:0];
                    highWord = product[2*wordWidth-1:wordWidth];
                end
                opDiv: begin
                    lowWord  = quotient;
                    highWord = remainder;
                end
                opNeg:  lowWord = -b;             // unary ops take the bus.
                opNot:  lowWord = ~b;
                opNop:  lowWord = b;
                default: lowWord = '0;
            endcase
        end
    end

    assign result = {highWord, lowWord};      // straight into Z.

endmodule

// ==== common/srcPkg.sv ====
package srcPkg;

    // datapath sizes.
    localparam int wordWidth    = 32;                  // one bus word.
    localparam int regCount     = 16;                  // r0 to r15.
    localparam int regSelWidth  = 4;                   // register number width.
    localparam int memDepth     = 512;                 // words of memory.
    localparam int memAddrWidth = 9;                   // low bits of MAR.

    // instruction register field positions.
    localparam int raMsb   = 26;                       // Ra field.
    localparam int raLsb   = 23;
    localparam int rbMsb   = 22;                       // Rb field.
    localparam int rbLsb   = 19;
    localparam int rcMsb   = 18;                       // Rc field.
    localparam int rcLsb   = 15;
    localparam int condMsb = 20;                       // branch condition, overlaps Rb.
    localparam int condLsb = 19;
    localparam int immWidth = 19;                      // immediate, bits 18..0.

    // ALU operations, numbered after the Mini SRC opcodes.
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,                             // a + b.
        opSub  = 5'b00100,                             // a - b.
        opAnd  = 5'b00101,                             // bitwise and.
        opOr   = 5'b00110,                             // bitwise or.
        opRor  = 5'b00111,                             // rotate right.
        opRol  = 5'b01000,                             // rotate left.
        opShr  = 5'b01001,                             // logical shift right.
        opShra = 5'b01010,                             // arithmetic shift right.
        opShl  = 5'b01011,                             // shift left.
        opDiv  = 5'b01111,                             // quotient low, remainder high.
        opMul  = 5'b10000,                             // full 64-bit product.
        opNeg  = 5'b10001,                             // two's complement of b.
        opNot  = 5'b10010,                             // inverse of b.
        opNop  = 5'b11010                              // pass b.
    } aluOp_t;

    // branch conditions, from the c2 field of the branch instruction.
    typedef enum logic [1:0] {
        condZero     = 2'b00,                          // brzr.
        condNonZero  = 2'b01,                          // brnz.
        condPositive = 2'b10,                          // brpl.
        condNegative = 2'b11                           // brmi.
    } condition_t;

endpackage

// ==== rtl/conditionLogic.sv ====
`timescale 1ns/1ps

module conditionLogic (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [srcPkg::wordWidth-1:0] busIn,
    input  logic [srcPkg::wordWidth-1:0] ir,
    input  logic                         conIn,
    output logic                         conFlag
);
    import srcPkg::*;

    condition_t cond;                          // from IR c2 field.
    logic       condMet;
    logic       isZero;

    assign cond   = condition_t'(ir[condMsb:condLsb]);
    assign isZero = (busIn == '0);

    always_comb begin
        case (cond)
            condZero:     condMet = isZero;
            condNonZero:  condMet = !isZero;
            condPositive: condMet = !busIn[wordWidth-1];   // sign bit clear.
            condNegative: condMet = busIn[wordWidth-1];
            default:      condMet = 1'b0;
        endcase
    end

    // CON flip-flop, holds between branches.
    always_ff @(posedge clock) begin
        if (reset) begin
            conFlag <= 1'b0;
        end else if (conIn) begin
            conFlag <= condMet;                // Ra value is on the bus.
        end
    end

endmodule

// ==== rtl/memoryInterface.sv ====
`timescale 1ns/1ps

module memoryInterface (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [srcPkg::wordWidth-1:0] busIn,
    input  logic                         marIn,
    input  logic                         mdrIn,
    input  logic                         memRead,
    input  logic                         memWrite,
    output logic [srcPkg::wordWidth-1:0] mdrOut
);
    import srcPkg::*;

    logic [wordWidth-1:0]    mem [memDepth];   // word memory.
    logic [wordWidth-1:0]    mar;
    logic [wordWidth-1:0]    mdr;
    logic [memAddrWidth-1:0] memAddr;          // MAR modulo depth.

    assign memAddr = mar[memAddrWidth-1:0];

    // address and data registers.
    always_ff @(posedge clock) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marIn) begin
                mar <= busIn;
            end
            if (mdrIn) begin
                // memRead picks memory over the bus.
                mdr <= memRead ? mem[memAddr] : busIn;
            end
        end
    end

    // write port, MDR into memory.
    always_ff @(posedge clock) begin
        if (memWrite) begin
            mem[memAddr] <= mdr;               // old MDR if mdrIn same cycle.
        end
    end

    assign mdrOut = mdr;

endmodule

// ==== rtl/miniSrc.sv ====
`timescale 1ns/1ps

module miniSrc (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [srcPkg::wordWidth-1:0] inPortData,
    input  logic                         gra,
    input  logic                         grb,
    input  logic                         grc,
    input  logic                         rIn,
    input  logic                         rOut,
    input  logic                         baOut,
    input  logic                         pcOut,
    input  logic                         incPc,
    input  logic                         pcIn,
    input  logic                         irIn,
    input  logic                         yIn,
    input  logic                         hiOut,
    input  logic                         hiIn,
    input  logic                         loOut,
    input  logic                         loIn,
    input  logic                         cOut,
    input  logic                         zHighOut,
    input  logic                         zLowOut,
    input  logic                         zIn,
    input  logic                         mdrOut,
    input  logic                         mdrIn,
    input  logic                         marIn,
    input  logic                         memRead,
    input  logic                         memWrite,
    input  logic                         inPortIn,
    input  logic                         inPortOut,
    input  logic                         outPortIn,
    input  logic                         conIn,
    input  srcPkg::aluOp_t               aluOp,
    output logic [srcPkg::wordWidth-1:0] outPortData,
    output logic                         conFlag
);
    import srcPkg::*;

    logic [wordWidth-1:0]   bus;
    logic [wordWidth-1:0]   pc;
    logic [wordWidth-1:0]   ir;
    logic [wordWidth-1:0]   y;            // ALU operand A.
    logic [2*wordWidth-1:0] z;            // ALU result, both words.
    logic [wordWidth-1:0]   hi;
    logic [wordWidth-1:0]   lo;
    logic [wordWidth-1:0]   inPortReg;
    logic [wordWidth-1:0]   outPortReg;
    logic [wordWidth-1:0]   regData;      // already gated by rOut/baOut.
    logic [wordWidth-1:0]   mdrData;
    logic [wordWidth-1:0]   cSignExt;     // immediate from IR.
    logic [2*wordWidth-1:0] aluResult;

    assign cSignExt = {{(wordWidth-immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};

    // one-hot bus mux; zero when nothing drives.
    assign bus = regData
               | ({wordWidth{pcOut}}     & pc)
               | ({wordWidth{mdrOut}}    & mdrData)
               | ({wordWidth{hiOut}}     & hi)
               | ({wordWidth{loOut}}     & lo)
               | ({wordWidth{zHighOut}}  & z[2*wordWidth-1:wordWidth])
               | ({wordWidth{zLowOut}}   & z[wordWidth-1:0])
               | ({wordWidth{inPortOut}} & inPortReg)
               | ({wordWidth{cOut}}      & cSignExt);

    // bus-side registers. a branch loads PC only when pcIn is raised,
    // which is gated by conFlag outside the datapath.
    always_ff @(posedge clock) begin
        if (reset) begin
            pc         <= '0;
            ir         <= '0;
            y          <= '0;
            z          <= '0;
            hi         <= '0;
            lo         <= '0;
            inPortReg  <= '0;
            outPortReg <= '0;
        end else begin
            if (pcIn)      pc         <= bus;
            if (irIn)      ir         <= bus;
            if (yIn)       y          <= bus;
            if (zIn)       z          <= aluResult;    // Y op bus.
            if (hiIn)      hi         <= bus;
            if (loIn)      lo         <= bus;
            if (inPortIn)  inPortReg  <= inPortData;   // external sample.
            if (outPortIn) outPortReg <= bus;
        end
    end

    assign outPortData = outPortReg;

    registerFile u_registerFile (
        .clock  (clock),
        .reset  (reset),
        .busIn  (bus),
        .ir     (ir),
        .gra    (gra),
        .grb    (grb),
        .grc    (grc),
        .rIn    (rIn),
        .rOut   (rOut),
        .baOut  (baOut),
        .regOut (regData)
    );

    alu u_alu (
        .a      (y),
        .b      (bus),
        .aluOp  (aluOp),
        .incPc  (incPc),
        .result (aluResult)
    );

    conditionLogic u_conditionLogic (
        .clock   (clock),
        .reset   (reset),
        .busIn   (bus),
        .ir      (ir),
        .conIn   (conIn),
        .conFlag (conFlag)
    );

    memoryInterface u_memoryInterface (
        .clock    (clock),
        .reset    (reset),
        .busIn    (bus),
        .marIn    (marIn),
        .mdrIn    (mdrIn),
        .memRead  (memRead),
        .memWrite (memWrite),
        .mdrOut   (mdrData)
    );

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [srcPkg::wordWidth-1:0] busIn,
    input  logic [srcPkg::wordWidth-1:0] ir,
    input  logic                         gra,
    input  logic                         grb,
    input  logic                         grc,
    input  logic                         rIn,
    input  logic                         rOut,
    input  logic                         baOut,
    output logic [srcPkg::wordWidth-1:0] regOut
);
    import srcPkg::*;

    logic [wordWidth-1:0]   regs [regCount];       // general registers.
    logic [regSelWidth-1:0] sel;                   // decoded register number.
    logic                   readEnable;            // drive a value onto regOut.

    // select logic, one field at a time.
    always_comb begin
        if (gra) begin
            sel = ir[raMsb:raLsb];                 // Ra.
        end else if (grb) begin
            sel = ir[rbMsb:rbLsb];                 // Rb.
        end else if (grc) begin
            sel = ir[rcMsb:rcLsb];                 // Rc.
        end else begin
            sel = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;                     // all registers cleared.
            end
        end else if (rIn) begin
            regs[sel] <= busIn;                    // r0 stays writable.
        end
    end

    // baOut reads r0 as zero for base addressing, rOut reads it as stored.
    assign readEnable = rOut || (baOut && (sel != '0));
    assign regOut     = readEnable ? regs[sel] : '0;

endmodule

// ==== sources.f ====
common/srcPkg.sv
rtl/registerFile.sv
alu/alu.sv
rtl/conditionLogic.sv
rtl/memoryInterface.sv
rtl/miniSrc.sv
test/clockGen.sv
test/miniSrc_assertions.sv
test/miniSrcTb.sv

// ==== test/branch_trace.txt ====
# columns: strobes (bit0 gra .. bit27 conIn), aluOp, inPortData, check, outPortData, conFlag
# one line per clock; outputs are compared after the edge that ends the line
0000000 1A 00000000 1 00000000 0
1000000 1A 01800000 0 00000000 0
2000200 1A 00000000 0 00000000 0
1000000 1A 8765ABCD 0 00000000 0
2000009 1A 00000000 0 00000000 0
4000011 1A 00000000 1 8765ABCD 0
200000A 1A 00000000 0 00000000 0
4000022 1A 00000000 1 00000000 0
4000012 1A 00000000 1 8765ABCD 0
0000411 1A 00000000 0 00000000 0
1000000 1A 00000004 0 00000000 0
2040000 1A 00000000 0 00000000 0
4060000 09 00000000 1 00000004 0
4060000 03 00000000 1 08765ABC 0
4060000 04 00000000 1 8FDC0689 0
4060000 05 00000000 1 F789A544 0
4060000 0A 00000000 1 8701A144 0
4060000 08 00000000 1 F8765ABC 0
4060000 0B 00000000 1 D8765ABC 0
4060000 06 00000000 1 D0000000 0
4060000 12 00000000 1 D765ABCD 0
4060000 11 00000000 1 289A5432 0
4060000 07 00000000 1 D765ABCE 0
4020000 1A 00000000 1 AF361D96 0
2040000 10 00000000 0 00000000 0
4010000 1A 00000000 1 FFFFFFFE 0
4020000 1A 00000000 1 1D96AF34 0
2040000 0F 00000000 0 00000000 0
4010000 1A 00000000 1 FFFFFFFD 0
4020000 1A 00000000 1 E1D96AF4 0
0040000 0F 00000000 0 00000000 0
0011000 1A 00000000 0 00000000 0
0024000 1A 00000000 0 00000000 0
4000800 1A 00000000 1 8765ABCD 0
4002000 1A 00000000 1 FFFFFFFF 0
1202000 1A 01880010 0 00000000 0
2100000 1A 00000000 0 00000000 0
0B00040 1A 00000000 0 00000000 0
0202000 1A 00000000 0 00000000 0
0500000 1A 00000000 0 00000000 0
4080200 1A 00000000 1 01880010 0
00400C0 1A 00000000 0 00000000 0
4020100 1A 00000000 1 00000001 0
8000011 1A 00000000 1 00000001 1
0000440 1A 00000000 0 00000000 0
0048000 03 00000000 0 00000000 0
0020100 1A 00000000 0 00000000 0
4000040 1A 00000000 1 00000011 1
1000440 1A 01800010 0 00000000 0
2000200 1A 00000000 0 00000000 0
8000011 1A 00000000 1 00000011 0
0048000 03 00000000 0 00000000 0
4000040 1A 00000000 1 00000011 0
1000000 1A 01900010 0 00000000 0
2000200 1A 00000000 0 00000000 0
8000011 1A 00000000 1 00000011 0
1000000 1A 01980010 0 00000000 0
2000200 1A 00000000 0 00000000 0
8000011 1A 00000000 1 00000011 1

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clock,
    output logic reset
);

    localparam time halfPeriod = 50ns;         // 100 ns clock.

    initial begin
        clock = 1'b0;
        reset = 1'b1;                          // held from time zero.
        repeat (2) @(posedge clock);
        #1ns;
        reset = 1'b0;                          // released after two edges.
    end

    always #halfPeriod clock = ~clock;

endmodule

// ==== test/miniSrcTb.sv ====
`timescale 1ns/1ps

module miniSrcTb;
    import srcPkg::*;

    logic                 clock;
    logic                 reset;
    logic [27:0]          ctrl;                // strobes, bit order as in the trace.
    aluOp_t               aluOp;
    logic [wordWidth-1:0] inPortData;
    logic [wordWidth-1:0] outPortData;
    logic                 conFlag;

    logic [27:0]          ctrlQ[$];
    logic [4:0]           opQ[$];
    logic [wordWidth-1:0] dataQ[$];
    logic                 chkQ[$];
    logic [wordWidth-1:0] expOutQ[$];
    logic                 expConQ[$];
    int                   cycleCount;
    int                   cycleLimit;

    clockGen clockGen_i (.clock(clock), .reset(reset));

    miniSrc dut_i (
        .clock(clock), .reset(reset), .inPortData(inPortData),
        .gra(ctrl[0]), .grb(ctrl[1]), .grc(ctrl[2]), .rIn(ctrl[3]),
        .rOut(ctrl[4]), .baOut(ctrl[5]), .pcOut(ctrl[6]), .incPc(ctrl[7]),
        .pcIn(ctrl[8]), .irIn(ctrl[9]), .yIn(ctrl[10]), .hiOut(ctrl[11]),
        .hiIn(ctrl[12]), .loOut(ctrl[13]), .loIn(ctrl[14]), .cOut(ctrl[15]),
        .zHighOut(ctrl[16]), .zLowOut(ctrl[17]), .zIn(ctrl[18]),
        .mdrOut(ctrl[19]), .mdrIn(ctrl[20]), .marIn(ctrl[21]),
        .memRead(ctrl[22]), .memWrite(ctrl[23]), .inPortIn(ctrl[24]),
        .inPortOut(ctrl[25]), .outPortIn(ctrl[26]), .conIn(ctrl[27]),
        .aluOp(aluOp), .outPortData(outPortData), .conFlag(conFlag)
    );

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic loadTrace();
        int    fd;
        int    count;
        string line;
        logic [27:0] c;
        logic [4:0]  o;
        logic [31:0] d;
        logic [31:0] e;
        logic        k;
        logic        f;
        fd = $fopen("test/branch_trace.txt", "r");
        if (fd == 0) begin
            $display("Test failed");
            $fatal(1, "could not open the trace file");
        end
        while (!$feof(fd)) begin
            line  = "";
            count = $fgets(line, fd);
            count = $sscanf(line, "%h %h %h %h %h %h", c, o, d, k, e, f);
            if (count == 6) begin              // comment and blank lines skipped.
                ctrlQ.push_back(c);
                opQ.push_back(o);
                dataQ.push_back(d);
                chkQ.push_back(k);
                expOutQ.push_back(e);
                expConQ.push_back(f);
            end
        end
        $fclose(fd);
    endtask

    // run limit, trace length plus slack for reset.
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Test failed");
            $fatal(1, "run did not finish within %0d cycles", cycleLimit);
        end
    end

    initial begin
        ctrl       = '0;
        aluOp      = opNop;
        inPortData = '0;
        cycleCount = 0;
        cycleLimit = 20;
        loadTrace();
        if (ctrlQ.size() == 0) begin
            $display("Test failed");
            $fatal(1, "trace file holds no stimulus lines");
        end
        cycleLimit = ctrlQ.size() + 20;
        @(negedge reset);                      // 1 ns after an edge.
        for (int i = 0; i < ctrlQ.size(); i++) begin
            ctrl       = ctrlQ[i];
            aluOp      = aluOp_t'(opQ[i]);
            inPortData = dataQ[i];
            @(posedge clock);
            #1ns;                              // outputs settled after the edge.
            if (chkQ[i]) begin
                compareValue("outPortData", expOutQ[i], outPortData);
                compareValue("conFlag", {31'b0, expConQ[i]}, {31'b0, conFlag});
            end
        end
        ctrl = '0;
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== test/miniSrc_assertions.sv ====
`timescale 1ns/1ps

module miniSrc_assertions (
    input logic        clock,
    input logic        reset,
    input logic        rOut,
    input logic        baOut,
    input logic        pcOut,
    input logic        mdrOut,
    input logic        hiOut,
    input logic        loOut,
    input logic        zHighOut,
    input logic        zLowOut,
    input logic        inPortOut,
    input logic        cOut,
    input logic        conIn,
    input logic        conFlag,
    input logic [31:0] outPortData
);

    // single bus driver per cycle.
    busOneDriver: assert property (@(posedge clock) disable iff (reset)
        $onehot0({rOut, baOut, pcOut, mdrOut, hiOut, loOut,
                  zHighOut, zLowOut, inPortOut, cOut}))
        else $error("more than one bus source enabled");

    // CON flip-flop moves only after a conIn cycle.
    conOnlyOnLoad: assert property (@(posedge clock) disable iff (reset)
        (conFlag != $past(conFlag)) |-> $past(conIn))
        else $error("conFlag changed without conIn");

    outPortCleared: assert property (@(posedge clock)
        reset |=> (outPortData == '0))
        else $error("output port not cleared by reset");

endmodule

bind miniSrc miniSrc_assertions assertions_i (.*);
